// ==== files.f ====
hw/apb_iob_pkg.sv
hw/apb2iob_bridge.sv
hw/iob_req_fifo.sv
hw/iob_sram_subordinate.sv
hw/apb_iob_top.sv
verif/tb_clk_gen.sv
verif/tb_apb_iob.sv

// ==== hw/apb2iob_bridge.sv ====
/*
 * APB subordinate FSM issuing one IOb request per APB access
 * Registered APB ready and read data capture on rvalid
 */

`timescale 1ns/1ps
`default_nettype none

module apb2iob_bridge (
   input  logic                              clk_i,
   input  logic                              rst_i,

   // APB subordinate side
   input  apb_iob_pkg::apb_req_t             apb_req_i,
   output logic                              apb_ready_o,
   output logic [apb_iob_pkg::DATA_W-1:0]    apb_rdata_o,

   // IOb manager side
   output logic                              iob_valid_o,
   output apb_iob_pkg::iob_req_t             iob_req_o,
   input  logic                              iob_ready_i,
   input  apb_iob_pkg::iob_rsp_t             iob_rsp_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT_RD,
      ST_ACK
   } state_t;

   state_t                           state_q;
   state_t                           state_d;
   logic                             apb_ready_d;
   logic                             apb_ready_q;
   logic [apb_iob_pkg::DATA_W-1:0]   rdata_q;

   // Request follows the APB bus, which the manager holds for the whole access
   assign iob_req_o.addr  = apb_req_i.addr;
   assign iob_req_o.wdata = apb_req_i.wdata;
   assign iob_req_o.wstrb = apb_req_i.write ? apb_req_i.wstrb
                                            : {apb_iob_pkg::WSTRB_W{1'b0}};

   assign iob_valid_o = (state_q == ST_REQ);
   assign apb_ready_o = apb_ready_q;
   assign apb_rdata_o = rdata_q;

   always_comb begin
      state_d     = state_q;
      apb_ready_d = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (apb_req_i.sel && apb_req_i.enable) begin
               state_d = ST_REQ;
            end
         end
         ST_REQ: begin
            if (iob_ready_i) begin
               if (apb_req_i.write) begin
                  // Posted write, done once the FIFO took it
                  state_d     = ST_ACK;
                  apb_ready_d = 1'b1;
               end else begin
                  state_d = ST_WAIT_RD;
               end
            end
         end
         ST_WAIT_RD: begin
            if (iob_rsp_i.rvalid) begin
               state_d     = ST_ACK;
               apb_ready_d = 1'b1;
            end
         end
         default: begin
            state_d = ST_IDLE;           // ACK lasts one cycle
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= ST_IDLE;
         apb_ready_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         apb_ready_q <= apb_ready_d;
      end
   end

   // Read data held until the next read returns
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rdata_q <= '0;
      end else if (iob_rsp_i.rvalid) begin
         rdata_q <= iob_rsp_i.rdata;
      end
   end

   // A stalled request must not move, which relies on the APB manager holding its bus
   a_req_stable: assert property (
      @(posedge clk_i) disable iff (rst_i)
      iob_valid_o && !iob_ready_i |=> $stable(iob_req_o)
   );

endmodule

`default_nettype wire

// ==== hw/apb_iob_pkg.sv ====
/*
 * Shared bus widths, FIFO depth and the APB and IOb request/response structs
 */

`default_nettype none

package apb_iob_pkg;

   localparam int APB_ADDR_W = 8;              // Byte address
   localparam int DATA_W     = 32;
   localparam int WSTRB_W    = DATA_W / 8;     // One strobe per byte lane
   localparam int MEM_ADDR_W = 6;              // 64 words
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = 2;

   // Manager-driven APB signals
   typedef struct packed {
      logic                  sel;
      logic                  enable;
      logic                  write;
      logic [APB_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
      logic [WSTRB_W-1:0]    wstrb;
   } apb_req_t;

   // Zero wstrb marks a read
   typedef struct packed {
      logic [APB_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     wdata;
      logic [WSTRB_W-1:0]    wstrb;
   } iob_req_t;

   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } iob_rsp_t;

endpackage

`default_nettype wire

// ==== hw/apb_iob_top.sv ====
/*
 * Top level: APB bridge, request FIFO and memory subordinate
 */

`timescale 1ns/1ps
`default_nettype none

module apb_iob_top (
   input  logic                              clk_i,
   input  logic                              rst_i,
   input  logic                              stall_i,
   input  apb_iob_pkg::apb_req_t             apb_req_i,
   output logic                              apb_ready_o,
   output logic [apb_iob_pkg::DATA_W-1:0]    apb_rdata_o
);

   logic                    iob_valid;
   logic                    iob_ready;
   apb_iob_pkg::iob_req_t   iob_req;
   logic                    fifo_empty;
   apb_iob_pkg::iob_req_t   fifo_head;
   logic                    mem_pop;
   apb_iob_pkg::iob_rsp_t   iob_rsp;

   apb2iob_bridge u_bridge (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .apb_req_i   (apb_req_i),
      .apb_ready_o (apb_ready_o),
      .apb_rdata_o (apb_rdata_o),
      .iob_valid_o (iob_valid),
      .iob_req_o   (iob_req),
      .iob_ready_i (iob_ready),
      .iob_rsp_i   (iob_rsp)       // Straight from the memory
   );

   iob_req_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .push_i  (iob_valid),
      .req_i   (iob_req),
      .ready_o (iob_ready),
      .pop_i   (mem_pop),
      .empty_o (fifo_empty),
      .head_o  (fifo_head)
   );

   iob_sram_subordinate u_sram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .stall_i (stall_i),
      .empty_i (fifo_empty),
      .req_i   (fifo_head),
      .pop_o   (mem_pop),
      .rsp_o   (iob_rsp)
   );

endmodule

`default_nettype wire

// ==== hw/iob_req_fifo.sv ====
/*
 * Four-entry circular FIFO of IOb requests, ready while not full
 */

`timescale 1ns/1ps
`default_nettype none

module iob_req_fifo (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Write side, push_i acts as valid
   input  logic                    push_i,
   input  apb_iob_pkg::iob_req_t   req_i,
   output logic                    ready_o,

   // Read side
   input  logic                    pop_i,
   output logic                    empty_o,
   output apb_iob_pkg::iob_req_t   head_o
);

   apb_iob_pkg::iob_req_t                 buf_q [apb_iob_pkg::FIFO_DEPTH];
   logic [apb_iob_pkg::FIFO_PTR_W-1:0]    wr_ptr_q;
   logic [apb_iob_pkg::FIFO_PTR_W-1:0]    rd_ptr_q;
   logic [apb_iob_pkg::FIFO_PTR_W:0]      count_q;
   logic                                  full;
   logic                                  do_push;
   logic                                  do_pop;

   assign full    = (count_q == (apb_iob_pkg::FIFO_PTR_W + 1)'(apb_iob_pkg::FIFO_DEPTH));
   assign ready_o = !full;
   assign empty_o = (count_q == '0);
   assign head_o  = buf_q[rd_ptr_q];

   assign do_push = push_i && !full;
   assign do_pop  = pop_i && !empty_o;

   // Storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         buf_q[wr_ptr_q] <= req_i;
      end
   end

   // Pointers wrap on their own with a power-of-two depth
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;       // Both or neither
         endcase
      end
   end

   // Producer keeps the request up while the FIFO is full
   a_push_held: assert property (
      @(posedge clk_i) disable iff (rst_i)
      push_i && full |=> push_i
   );

   // Consumer only takes the head when there is one
   a_no_pop_empty: assert property (
      @(posedge clk_i) disable iff (rst_i)
      pop_i |-> !empty_o
   );

endmodule

`default_nettype wire

// ==== hw/iob_sram_subordinate.sv ====
/*
 * 64-word byte-writable memory serving queued IOb requests
 * Read data returned one cycle after the pop
 */

`timescale 1ns/1ps
`default_nettype none

module iob_sram_subordinate (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    stall_i,   // Holds off all pops

   // Request FIFO head
   input  logic                    empty_i,
   input  apb_iob_pkg::iob_req_t   req_i,
   output logic                    pop_o,

   // Read response
   output apb_iob_pkg::iob_rsp_t   rsp_o
);

   logic [apb_iob_pkg::DATA_W-1:0]       mem_q [2**apb_iob_pkg::MEM_ADDR_W];
   logic [apb_iob_pkg::MEM_ADDR_W-1:0]   word_idx;
   logic                                 is_read;
   logic                                 rvalid_q;
   logic [apb_iob_pkg::DATA_W-1:0]       rdata_q;

   // Word index from the byte address
   assign word_idx = req_i.addr[apb_iob_pkg::MEM_ADDR_W+1:2];
   assign is_read  = (req_i.wstrb == '0);
   assign pop_o    = !empty_i && !stall_i;

   assign rsp_o.rvalid = rvalid_q;
   assign rsp_o.rdata  = rdata_q;

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         if (is_read) begin
            rdata_q <= mem_q[word_idx];
         end else begin
            // Merge only the enabled byte lanes
            for (int b = 0; b < apb_iob_pkg::WSTRB_W; b++) begin
               if (req_i.wstrb[b]) begin
                  mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= pop_o && is_read;
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_apb_iob -f files.f -o tb_apb_iob \
   && ./obj_dir/tb_apb_iob | tee /dev/stderr | grep "^RESULT: PASS$" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== verif/tb_apb_iob.sv ====
/*
 * Testbench top: APB driver tasks, compare tasks, word memory model
 * and directed tests for the APB to IOb memory path
 */

`timescale 1ns/1ps
`default_nettype none

module tb_apb_iob;

   logic                                  clk;
   logic                                  rst;
   logic                                  stall;
   apb_iob_pkg::apb_req_t                 apb_req;
   logic                                  apb_ready;
   logic [apb_iob_pkg::DATA_W-1:0]        apb_rdata;

   // Reference memory with a flag per fully defined word
   logic [apb_iob_pkg::DATA_W-1:0]        model [2**apb_iob_pkg::MEM_ADDR_W];
   logic                                  known [2**apb_iob_pkg::MEM_ADDR_W];
   string                                 cur_test;
   int                                    err_count;
   int                                    test_err_start;
   int                                    tests_passed;
   int                                    tests_failed;

   tb_clk_gen u_clk_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   apb_iob_top u_dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .stall_i     (stall),
      .apb_req_i   (apb_req),
      .apb_ready_o (apb_ready),
      .apb_rdata_o (apb_rdata)
   );

   task automatic check_data(input string name, input logic [apb_iob_pkg::DATA_W-1:0] exp,
                             input logic [apb_iob_pkg::DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         err_count++;
      end
   endtask

   // Byte lanes with a set strobe take the new data
   function automatic void model_write(input logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx,
                                       input logic [apb_iob_pkg::DATA_W-1:0] data,
                                       input logic [apb_iob_pkg::WSTRB_W-1:0] strb);
      for (int b = 0; b < apb_iob_pkg::WSTRB_W; b++) begin
         if (strb[b]) begin
            model[idx][8*b +: 8] = data[8*b +: 8];
         end
      end
      if (strb == '1) begin
         known[idx] = 1'b1;
      end
   endfunction

   task automatic start_test(input string name);
      cur_test       = name;
      test_err_start = err_count;
   endtask

   task automatic end_test();
      if (err_count == test_err_start) begin
         tests_passed++;
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, err_count - test_err_start);
      end
   endtask

   // Drives the setup phase and enters the access phase on a falling edge
   task automatic apb_setup(input logic is_write, input logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx,
                            input logic [apb_iob_pkg::DATA_W-1:0] data,
                            input logic [apb_iob_pkg::WSTRB_W-1:0] strb);
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      apb_req.write  = is_write;
      apb_req.addr   = {idx, 2'b00};
      apb_req.wdata  = data;
      apb_req.wstrb  = is_write ? strb : '0;
      @(negedge clk);
      check_flag(cur_test, 1'b0, apb_ready);      // No completion during setup
      apb_req.enable = 1'b1;
   endtask

   task automatic wait_ready(output bit ok);
      int cycles;
      cycles = 0;
      ok     = 1'b0;
      while (!ok && cycles < 200) begin
         @(negedge clk);
         cycles++;
         if (apb_ready) begin
            ok = 1'b1;
         end
      end
      if (!ok) begin
         $display("%s: APB access got no ready within 200 cycles", cur_test);
         err_count++;
      end
   endtask

   // Ready has to drop once the transfer ends on the next rising edge
   task automatic apb_finish();
      @(negedge clk);
      apb_req.sel    = 1'b0;
      apb_req.enable = 1'b0;
      check_flag(cur_test, 1'b0, apb_ready);
   endtask

   task automatic apb_write(input logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx,
                            input logic [apb_iob_pkg::DATA_W-1:0] data,
                            input logic [apb_iob_pkg::WSTRB_W-1:0] strb);
      bit ok;
      apb_setup(1'b1, idx, data, strb);
      wait_ready(ok);
      apb_finish();
      model_write(idx, data, strb);
   endtask

   task automatic apb_read(input logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx);
      bit ok;
      apb_setup(1'b0, idx, '0, '0);
      wait_ready(ok);
      if (ok) begin
         check_data(cur_test, model[idx], apb_rdata);
      end
      apb_finish();
   endtask

   task automatic test_reset_values();
      int cycles;
      start_test("reset");
      cycles = 0;
      while (rst !== 1'b0 && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (rst !== 1'b0) begin
         $display("%s: reset was never released", cur_test);
         err_count++;
      end
      @(negedge clk);
      check_flag(cur_test, 1'b0, apb_ready);
      check_data(cur_test, '0, apb_rdata);
      end_test();
   endtask

   task automatic test_word_write_read();
      logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx;
      start_test("word_wr_rd");
      idx = (apb_iob_pkg::MEM_ADDR_W)'($urandom());
      apb_write(idx, $urandom(), '1);
      apb_read(idx);
      end_test();
   endtask

   task automatic test_byte_strobes();
      logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx;
      start_test("byte_strobe");
      idx = (apb_iob_pkg::MEM_ADDR_W)'($urandom());
      apb_write(idx, $urandom(), '1);              // Defined starting word
      apb_write(idx, $urandom(), 4'b0001);
      apb_read(idx);
      apb_write(idx, $urandom(), 4'b0110);
      apb_read(idx);
      apb_write(idx, $urandom(), 4'b1000);
      apb_write(idx, $urandom(), 4'b0101);
      apb_read(idx);
      end_test();
   endtask

   task automatic test_random_sequence();
      logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx;
      logic [apb_iob_pkg::WSTRB_W-1:0]    strb;
      start_test("random_seq");
      for (int n = 0; n < 20; n++) begin
         idx = (apb_iob_pkg::MEM_ADDR_W)'($urandom());
         if (known[idx] && $urandom_range(0, 1) == 1) begin
            apb_read(idx);
         end else begin
            // Partial strobes only on words that are fully defined
            strb = known[idx] ? (apb_iob_pkg::WSTRB_W)'($urandom_range(1, 15)) : '1;
            apb_write(idx, $urandom(), strb);
         end
      end
      end_test();
   endtask

   task automatic test_back_pressure();
      logic [apb_iob_pkg::MEM_ADDR_W-1:0] base;
      logic [apb_iob_pkg::MEM_ADDR_W-1:0] idx;
      logic [apb_iob_pkg::DATA_W-1:0]     data;
      logic                               seen_ready;
      bit                                 ok;
      start_test("back_pressure");
      base  = (apb_iob_pkg::MEM_ADDR_W)'($urandom());
      stall = 1'b1;
      for (int k = 0; k < apb_iob_pkg::FIFO_DEPTH; k++) begin
         idx = base + (apb_iob_pkg::MEM_ADDR_W)'(k);
         apb_write(idx, $urandom(), '1);           // Posted into the FIFO
      end
      // FIFO is full now, so this one has to wait
      idx  = base + (apb_iob_pkg::MEM_ADDR_W)'(apb_iob_pkg::FIFO_DEPTH);
      data = $urandom();
      apb_setup(1'b1, idx, data, '1);
      seen_ready = 1'b0;
      repeat (20) begin
         @(negedge clk);
         seen_ready = seen_ready | apb_ready;
      end
      check_flag(cur_test, 1'b0, seen_ready);
      stall = 1'b0;
      wait_ready(ok);
      apb_finish();
      model_write(idx, data, '1);
      apb_read(base);                              // Oldest write went first
      apb_read(idx);
      end_test();
   endtask

   initial begin
      apb_req      = '0;
      stall        = 1'b0;
      cur_test     = "";
      err_count    = 0;
      tests_passed = 0;
      tests_failed = 0;
      void'($urandom(50));
      for (int i = 0; i < 2**apb_iob_pkg::MEM_ADDR_W; i++) begin
         known[i] = 1'b0;
      end

      test_reset_values();
      test_word_write_read();
      test_byte_strobes();
      test_random_sequence();
      test_back_pressure();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && err_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
/*
 * Testbench clock and synchronous reset source
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   always #5 clk_o = ~clk_o;     // 10 ns period

   initial begin
      clk_o = 1'b0;
      rst_o = 1'b1;
      // Held over two rising edges, released on a falling edge
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire
